//--- cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// machine word width
`define CPU_DATA_WIDTH 16

// word address into main memory
`define CPU_ADDR_WIDTH 8

// number of memory words
// must match 2**CPU_ADDR_WIDTH so the pc wraps cleanly
`define CPU_MEM_DEPTH 256

// instruction field widths
`define CPU_CLASS_WIDTH 4
`define CPU_OP_WIDTH 4

`endif

//--- cpuPkg.sv
`include "cpu_cfg.svh"

package cpuPkg;

    // instruction class, top nibble of an instruction word
    // code 0 and any unlisted code execute as a no-op
    typedef enum logic [`CPU_CLASS_WIDTH-1:0] {
        classLoad     = 4'h1,
        classLoadImm  = 4'h2,
        classStore    = 4'h3,
        classAlu      = 4'h4,
        classJump     = 4'h5,
        classJumpZero = 4'h6,
        classHalt     = 4'hF
    } instrClass;

    // alu opcodes, arithmetic half below 4, logic half above
    typedef enum logic [`CPU_OP_WIDTH-1:0] {
        opAdd  = 4'd0,
        opSub  = 4'd1,
        opMul  = 4'd2,
        opDiv  = 4'd3,
        opShl  = 4'd4,
        opShr  = 4'd5,
        opRol  = 4'd6,
        opRor  = 4'd7,
        opAnd  = 4'd8,
        opOr   = 4'd9,
        opXor  = 4'd10,
        opNor  = 4'd11,
        opNand = 4'd12,
        opXnor = 4'd13,
        opGt   = 4'd14,
        opEq   = 4'd15
    } aluOp;

    // control sequencer states
    typedef enum logic [1:0] {
        stateIdle    = 2'd0,
        stateFetch   = 2'd1,
        stateDecode  = 2'd2,
        stateExecute = 2'd3
    } ctrlState;

    // instruction layout: class, opcode, address or immediate
    typedef struct packed {
        instrClass                 cls;
        aluOp                      op;
        logic [`CPU_ADDR_WIDTH-1:0] addr;
    } instrWord;

    // one executed store, seen from outside
    typedef struct packed {
        logic                       valid;
        logic [`CPU_ADDR_WIDTH-1:0] addr;
        logic [`CPU_DATA_WIDTH-1:0] data;
    } storeEvent;

endpackage

//--- arithUnit.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module arithUnit (
    input  logic [`CPU_DATA_WIDTH-1:0] a,
    input  logic [`CPU_DATA_WIDTH-1:0] b,
    input  cpuPkg::aluOp               op,
    output logic [`CPU_DATA_WIDTH-1:0] result
);

    // full product, only the low word is kept
    logic [2*`CPU_DATA_WIDTH-1:0] product;
    logic [`CPU_DATA_WIDTH-1:0]   quotient;

    assign product = a * b;

    // zero divisor defined as all ones
    always_comb begin
        if (b == '0) begin
            quotient = '1;
        end else begin
            quotient = a / b;
        end
    end

    always_comb begin
        case (op)
            // sum and difference wrap at word width
            cpuPkg::opAdd: result = a + b;
            cpuPkg::opSub: result = a - b;
            cpuPkg::opMul: result = product[`CPU_DATA_WIDTH-1:0];
            cpuPkg::opDiv: result = quotient;
            // logic half opcodes, not ours
            default: result = '0;
        endcase
    end

endmodule

//--- logicUnit.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module logicUnit (
    input  logic [`CPU_DATA_WIDTH-1:0] a,
    input  logic [`CPU_DATA_WIDTH-1:0] b,
    input  cpuPkg::aluOp               op,
    output logic [`CPU_DATA_WIDTH-1:0] result
);

    localparam int MSB = `CPU_DATA_WIDTH - 1;

    // compare flags, widened to a full word below
    logic gt;
    logic eq;

    // unsigned compare
    assign gt = (a > b);
    assign eq = (a == b);

    always_comb begin
        case (op)
            // single-bit shifts, zero fill
            cpuPkg::opShl: result = a << 1;
            cpuPkg::opShr: result = a >> 1;
            // rotates carry the edge bit around
            cpuPkg::opRol: result = {a[MSB-1:0], a[MSB]};
            cpuPkg::opRor: result = {a[0], a[MSB:1]};
            // bitwise group
            cpuPkg::opAnd:  result = a & b;
            cpuPkg::opOr:   result = a | b;
            cpuPkg::opXor:  result = a ^ b;
            cpuPkg::opNor:  result = ~(a | b);
            cpuPkg::opNand: result = ~(a & b);
            cpuPkg::opXnor: result = ~(a ^ b);
            // compares give 1 or 0
            cpuPkg::opGt: begin
                result = '0;
                result[0] = gt;
            end
            cpuPkg::opEq: begin
                result = '0;
                result[0] = eq;
            end
            // arithmetic half opcodes
            default: result = '0;
        endcase
    end

endmodule

//--- mainMemory.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module mainMemory (
    input  logic                       clk,
    input  logic                       loadEn,
    input  logic [`CPU_ADDR_WIDTH-1:0] loadAddr,
    input  logic [`CPU_DATA_WIDTH-1:0] loadData,
    input  logic [`CPU_ADDR_WIDTH-1:0] addr,
    input  logic                       wrEn,
    input  logic [`CPU_DATA_WIDTH-1:0] wrData,
    output logic [`CPU_DATA_WIDTH-1:0] rdData
);

    // unified program and data store
    logic [`CPU_DATA_WIDTH-1:0] mem [`CPU_MEM_DEPTH];

    // writes, load port first
    always_ff @(posedge clk) begin
        if (loadEn) begin
            mem[loadAddr] <= loadData;
        end else if (wrEn) begin
            mem[addr] <= wrData;
        end
    end

    // read every cycle from the core address
    // a write in the same cycle is not seen until the next read
    always_ff @(posedge clk) begin
        rdData <= mem[addr];
    end

endmodule

//--- cpuControl.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpuControl (
    input  logic                       clk,
    input  logic                       arstN,
    input  logic                       start,
    input  logic [`CPU_DATA_WIDTH-1:0] memRdData,
    input  logic [`CPU_DATA_WIDTH-1:0] arithResult,
    input  logic [`CPU_DATA_WIDTH-1:0] logicResult,
    output logic [`CPU_ADDR_WIDTH-1:0] memAddr,
    output logic                       memWrEn,
    output logic [`CPU_DATA_WIDTH-1:0] memWrData,
    output logic [`CPU_DATA_WIDTH-1:0] aluA,
    output logic [`CPU_DATA_WIDTH-1:0] aluB,
    output cpuPkg::aluOp               aluOpSel,
    output cpuPkg::storeEvent          store,
    output logic                       running,
    output logic                       halted,
    output logic [`CPU_DATA_WIDTH-1:0] acc
);

    cpuPkg::ctrlState           state;
    logic [`CPU_ADDR_WIDTH-1:0] pc;
    cpuPkg::instrWord           ir;
    // memory word viewed as an instruction during decode
    cpuPkg::instrWord           fetched;
    logic [`CPU_DATA_WIDTH-1:0] aluResult;
    logic                       jumpTaken;

    assign fetched = cpuPkg::instrWord'(memRdData);

    // fetch issues pc, decode the operand address, execute the target
    always_comb begin
        case (state)
            cpuPkg::stateDecode:  memAddr = fetched.addr;
            cpuPkg::stateExecute: memAddr = ir.addr;
            default:              memAddr = pc;
        endcase
    end

    // store lands at the end of execute
    assign memWrEn   = (state == cpuPkg::stateExecute) && (ir.cls == cpuPkg::classStore);
    assign memWrData = acc;

    // operand is whatever memory returned for the address field
    assign aluA     = acc;
    assign aluB     = memRdData;
    assign aluOpSel = ir.op;

    // arithmetic half owns opcodes 0 to 3
    assign aluResult = (ir.op < cpuPkg::opShl) ? arithResult : logicResult;

    assign jumpTaken = (ir.cls == cpuPkg::classJump) ||
                       ((ir.cls == cpuPkg::classJumpZero) && (acc == '0));

    // instruction register, latched at the end of decode
    always_ff @(posedge clk) begin
        if (state == cpuPkg::stateDecode) begin
            ir <= fetched;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state   <= cpuPkg::stateIdle;
            pc      <= '0;
            acc     <= '0;
            running <= 1'b0;
            halted  <= 1'b0;
            store   <= '0;
        end else begin
            // store events last one cycle
            store.valid <= 1'b0;
            case (state)
                cpuPkg::stateIdle: begin
                    if (start) begin
                        pc      <= '0;
                        acc     <= '0;
                        halted  <= 1'b0;
                        running <= 1'b1;
                        state   <= cpuPkg::stateFetch;
                    end
                end
                cpuPkg::stateFetch: begin
                    state <= cpuPkg::stateDecode;
                end
                cpuPkg::stateDecode: begin
                    state <= cpuPkg::stateExecute;
                end
                cpuPkg::stateExecute: begin
                    state <= cpuPkg::stateFetch;
                    // 8-bit pc wraps from 255 to 0 on its own
                    pc <= jumpTaken ? ir.addr : pc + 1'b1;
                    case (ir.cls)
                        cpuPkg::classLoad: acc <= memRdData;
                        cpuPkg::classLoadImm: begin
                            acc <= {{(`CPU_DATA_WIDTH-`CPU_ADDR_WIDTH){1'b0}}, ir.addr};
                        end
                        cpuPkg::classStore: begin
                            store.valid <= 1'b1;
                            store.addr  <= ir.addr;
                            store.data  <= acc;
                        end
                        cpuPkg::classAlu: acc <= aluResult;
                        cpuPkg::classHalt: begin
                            running <= 1'b0;
                            halted  <= 1'b1;
                            state   <= cpuPkg::stateIdle;
                        end
                        // jumps only move pc, unknown classes do nothing
                        default: ;
                    endcase
                end
                default: state <= cpuPkg::stateIdle;
            endcase
        end
    end

endmodule

//--- computer.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module computer (
    input  logic                       clk,
    input  logic                       arstN,
    input  logic                       loadEn,
    input  logic [`CPU_ADDR_WIDTH-1:0] loadAddr,
    input  logic [`CPU_DATA_WIDTH-1:0] loadData,
    input  logic                       start,
    output cpuPkg::storeEvent          store,
    output logic                       running,
    output logic                       halted,
    output logic [`CPU_DATA_WIDTH-1:0] acc
);

    // core to memory
    logic [`CPU_ADDR_WIDTH-1:0] memAddr;
    logic                       memWrEn;
    logic [`CPU_DATA_WIDTH-1:0] memWrData;
    logic [`CPU_DATA_WIDTH-1:0] memRdData;

    // core to both alu halves
    logic [`CPU_DATA_WIDTH-1:0] aluA;
    logic [`CPU_DATA_WIDTH-1:0] aluB;
    cpuPkg::aluOp               aluOpSel;
    logic [`CPU_DATA_WIDTH-1:0] arithResult;
    logic [`CPU_DATA_WIDTH-1:0] logicResult;

    // load port only counts while the core is stopped
    mainMemory uMem (
        .clk      (clk),
        .loadEn   (loadEn && !running),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .addr     (memAddr),
        .wrEn     (memWrEn),
        .wrData   (memWrData),
        .rdData   (memRdData)
    );

    arithUnit uArith (.a(aluA), .b(aluB), .op(aluOpSel), .result(arithResult));

    logicUnit uLogic (.a(aluA), .b(aluB), .op(aluOpSel), .result(logicResult));

    cpuControl uCtrl (
        .clk         (clk),
        .arstN       (arstN),
        .start       (start),
        .memRdData   (memRdData),
        .arithResult (arithResult),
        .logicResult (logicResult),
        .memAddr     (memAddr),
        .memWrEn     (memWrEn),
        .memWrData   (memWrData),
        .aluA        (aluA),
        .aluB        (aluB),
        .aluOpSel    (aluOpSel),
        .store       (store),
        .running     (running),
        .halted      (halted),
        .acc         (acc)
    );

endmodule

//--- computerChecker.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module computerChecker (
    input  logic                       clk,
    input  logic                       arstN,
    input  logic                       start,
    input  cpuPkg::storeEvent          store,
    input  logic                       running,
    input  logic                       halted,
    input  logic [`CPU_DATA_WIDTH-1:0] acc,
    output logic                       testDone,
    output int                         passCount,
    output int                         failCount
);

    localparam int MAX_STORES = 32;

    // expected stores of the current test in order
    logic [`CPU_ADDR_WIDTH-1:0] expAddr [MAX_STORES];
    logic [`CPU_DATA_WIDTH-1:0] expData [MAX_STORES];
    logic [`CPU_DATA_WIDTH-1:0] expAcc;
    logic [8*16-1:0]            testName;
    int                         expCount;
    int                         seenCount;
    int                         instrCount;
    int                         cycles;
    int                         errors;
    int                         resetEdges;
    logic                       armed;
    logic                       active;

    initial begin
        testDone = 1'b1;
        passCount = 0;
        failCount = 0;
        resetEdges = 0;
        armed = 1'b0;
        active = 1'b0;
    end

    // new test stays armed until the start pulse is seen
    task automatic beginTest(input logic [8*16-1:0] name,
                             input logic [`CPU_DATA_WIDTH-1:0] accValue,
                             input int count);
        testName = name;
        expAcc = accValue;
        instrCount = count;
        expCount = 0;
        seenCount = 0;
        errors = 0;
        cycles = 0;
        active = 1'b0;
        armed = 1'b1;
        testDone = 1'b0;
    endtask

    task automatic addStore(input logic [`CPU_ADDR_WIDTH-1:0] addr,
                            input logic [`CPU_DATA_WIDTH-1:0] data);
        if (expCount < MAX_STORES) begin
            expAddr[expCount] = addr;
            expData[expCount] = data;
            expCount++;
        end
    endtask

    task automatic valueError(input string sig, input logic [15:0] expVal,
                              input logic [15:0] gotVal);
        $display("** Error at %0t ns: %0s expected %h got %h", $time, sig, expVal, gotVal);
        errors++;
    endtask

    task automatic tally(input logic [8*16-1:0] name);
        if (errors == 0) begin
            $display("test %0s: pass", name);
            passCount++;
        end else begin
            $display("test %0s: fail", name);
            failCount++;
        end
    endtask

    task automatic checkStore();
        if (seenCount >= expCount) begin
            $display("test %0s: store to %h with data %h at %0t ns was not expected",
                     testName, store.addr, store.data, $time);
            errors++;
        end else begin
            if (store.addr !== expAddr[seenCount]) valueError("store.addr", expAddr[seenCount],
                                                              store.addr);
            if (store.data !== expData[seenCount]) valueError("store.data", expData[seenCount],
                                                              store.data);
            seenCount++;
        end
    endtask

    // final acc, running, leftover stores and run length once halted
    task automatic closeTest();
        if (acc !== expAcc) valueError("acc", expAcc, acc);
        if (running !== 1'b0) valueError("running", 16'h0, running);
        if (seenCount < expCount) begin
            $display("test %0s: %0d expected stores never happened", testName,
                     expCount - seenCount);
            errors++;
        end
        if (cycles != 3 * instrCount + 1) begin
            $display("** Error at %0t ns: cycles from start to halted expected %0d got %0d",
                     $time, 3 * instrCount + 1, cycles);
            errors++;
        end
        tally(testName);
        testDone = 1'b1;
    endtask

    // registered outputs seen here still hold the previous edge's values
    always @(posedge clk) begin
        if (!arstN) begin
            resetEdges++;
            // async clear has landed by the second edge in reset
            if (resetEdges == 2) begin
                errors = 0;
                if (running !== 1'b0) valueError("running", 16'h0, running);
                if (halted !== 1'b0) valueError("halted", 16'h0, halted);
                if (store.valid !== 1'b0) valueError("store.valid", 16'h0, store.valid);
                if (acc !== '0) valueError("acc", 16'h0, acc);
                tally("reset");
            end
        end else if (armed) begin
            if (start) begin
                armed = 1'b0;
                active = 1'b1;
                cycles = 1;
            end
        end else if (active) begin
            // first edge after start expects halted cleared and running up
            if (cycles == 1 && (halted !== 1'b0 || running !== 1'b1)) begin
                $display("test %0s: start did not clear halted and raise running", testName);
                errors++;
            end
            if (store.valid === 1'b1) checkStore();
            if (halted === 1'b1) begin
                active = 1'b0;
                closeTest();
            end else begin
                cycles++;
            end
        end
    end

endmodule

//--- computerTb.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module computerTb;

    localparam int MAX_TESTS  = 8;
    localparam int MAX_WORDS  = 128;
    localparam int MAX_STORES = 64;

    logic                       clk;
    logic                       arstN;
    logic                       loadEn;
    logic [`CPU_ADDR_WIDTH-1:0] loadAddr;
    logic [`CPU_DATA_WIDTH-1:0] loadData;
    logic                       start;
    cpuPkg::storeEvent          store;
    logic                       running;
    logic                       halted;
    logic [`CPU_DATA_WIDTH-1:0] acc;
    logic                       testDone;
    int                         passCount;
    int                         failCount;

    // parsed tests with words and stores kept as index ranges
    logic [8*16-1:0]            testName [MAX_TESTS];
    int                         budget [MAX_TESTS];
    logic [`CPU_DATA_WIDTH-1:0] finalAcc [MAX_TESTS];
    int                         wordFirst [MAX_TESTS];
    int                         wordLast [MAX_TESTS];
    int                         storeFirst [MAX_TESTS];
    int                         storeLast [MAX_TESTS];
    logic [`CPU_ADDR_WIDTH-1:0] wordAddr [MAX_WORDS];
    logic [`CPU_DATA_WIDTH-1:0] wordData [MAX_WORDS];
    logic [`CPU_ADDR_WIDTH-1:0] storeAddr [MAX_STORES];
    logic [`CPU_DATA_WIDTH-1:0] storeData [MAX_STORES];
    int                         numTests;
    int                         cycleCount;
    int                         cycleLimit;

    computer UUT (
        .clk      (clk),
        .arstN    (arstN),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .start    (start),
        .store    (store),
        .running  (running),
        .halted   (halted),
        .acc      (acc)
    );

    computerChecker chk (
        .clk       (clk),
        .arstN     (arstN),
        .start     (start),
        .store     (store),
        .running   (running),
        .halted    (halted),
        .acc       (acc),
        .testDone  (testDone),
        .passCount (passCount),
        .failCount (failCount)
    );

    // 40 ns period
    always #20 clk = ~clk;

    // watchdog over the whole run
    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("timeout: run did not finish within %0d cycles", cycleLimit);
            $display("sim failed");
            $finish;
        end
    end

    task automatic readTests();
        int fd;
        int code;
        int count;
        int numWords;
        int numStores;
        logic [8*16-1:0]            keyword;
        logic [8*128-1:0]           skipped;
        logic [`CPU_ADDR_WIDTH-1:0] addr;
        logic [`CPU_DATA_WIDTH-1:0] data;
        numTests = 0;
        numWords = 0;
        numStores = 0;
        // reset cycles plus margin before each test adds its share
        cycleLimit = 4 + 50;
        fd = $fopen("computer_testdata.txt", "r");
        if (fd != 0) begin
            keyword = '0;
            code = $fscanf(fd, "%s", keyword);
            while (code == 1) begin
                if (keyword == "#") begin
                    code = $fgets(skipped, fd);
                end else if (keyword == "test") begin
                    code = $fscanf(fd, "%s %d", testName[numTests], budget[numTests]);
                    wordFirst[numTests] = numWords;
                    storeFirst[numTests] = numStores;
                end else if (keyword == "mem") begin
                    code = $fscanf(fd, "%h %d", addr, count);
                    // consecutive words from addr upward
                    for (int i = 0; i < count; i++) begin
                        code = $fscanf(fd, "%h", data);
                        wordAddr[numWords] = addr + i[`CPU_ADDR_WIDTH-1:0];
                        wordData[numWords] = data;
                        numWords++;
                    end
                end else if (keyword == "store") begin
                    code = $fscanf(fd, "%h %h", addr, data);
                    storeAddr[numStores] = addr;
                    storeData[numStores] = data;
                    numStores++;
                end else if (keyword == "acc") begin
                    code = $fscanf(fd, "%h", data);
                    finalAcc[numTests] = data;
                    wordLast[numTests] = numWords;
                    storeLast[numTests] = numStores;
                    // load cycles, start pulse, 3 per instruction and slack
                    cycleLimit += numWords - wordFirst[numTests] + 3 * budget[numTests] + 6;
                    numTests++;
                end
                keyword = '0;
                code = $fscanf(fd, "%s", keyword);
            end
            $fclose(fd);
        end
    endtask

    task automatic runTest(input int t);
        chk.beginTest(testName[t], finalAcc[t], budget[t]);
        for (int i = storeFirst[t]; i < storeLast[t]; i++) begin
            chk.addStore(storeAddr[i], storeData[i]);
        end
        // one word per cycle through the load port
        for (int i = wordFirst[t]; i < wordLast[t]; i++) begin
            @(negedge clk);
            loadEn = 1'b1;
            loadAddr = wordAddr[i];
            loadData = wordData[i];
        end
        @(negedge clk);
        loadEn = 1'b0;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (halted !== 1'b1) @(negedge clk);
        while (testDone !== 1'b1) @(negedge clk);
    endtask

    initial begin
        clk = 1'b0;
        arstN = 1'b0;
        loadEn = 1'b0;
        loadAddr = '0;
        loadData = '0;
        start = 1'b0;
        cycleCount = 0;
        readTests();
        if (numTests == 0) begin
            $display("no tests could be read from computer_testdata.txt");
            $display("sim failed");
            $finish;
        end else begin
            repeat (4) @(posedge clk);
            @(negedge clk);
            arstN = 1'b1;
            for (int t = 0; t < numTests; t++) begin
                runTest(t);
            end
            $display("tests passed %0d, failed %0d", passCount, failCount);
            // reset check counts as one extra test
            if (failCount == 0 && passCount == numTests + 1) begin
                $display("sim passed");
            end else begin
                $display("sim failed");
            end
            $finish;
        end
    end

endmodule

//--- computer_testdata.txt
# test <name> <instructions executed>; mem <hex addr> <count> <hex words>
# store <hex addr> <hex data> in order; acc <hex final accumulator> ends a test
test haltonly 1
mem 00 1 F000
acc 0000
test arith 12
mem 00 12 2007 4040 3080 4141 3081 4242 3082 4343 3083 4344 3084 F000
mem 40 5 0005 0010 1234 0007 0000
store 80 000C
store 81 FFFC
store 82 B730
store 83 1A2B
store 84 FFFF
acc FFFF
test logic 42
mem 00 42 1040 4440 3080 1040 4540 3081 1040 4640 3082 1040 4740 3083
  1041 4842 3084 1041 4942 3085 1041 4A42 3086 1041 4B42 3087 1041 4C42
  3088 1041 4D42 3089 1041 4E42 308A 1042 4E41 308B 1041 4F41 308C 4F42
  308D F000
mem 40 3 8001 F0F0 FF00
store 80 0002
store 81 4000
store 82 0003
store 83 C000
store 84 F000
store 85 FFF0
store 86 0FF0
store 87 000F
store 88 0FFF
store 89 F00F
store 8A 0000
store 8B 0001
store 8C 0001
store 8D 0000
acc 0000
test memory 8
mem 00 8 2055 3090 2000 1090 3091 4040 3092 F000
mem 40 1 1200
store 90 0055
store 91 0055
store 92 1255
acc 1255
test loop 15
mem 00 9 2003 3080 4140 6005 5001 7ABC 5008 20EE F000
mem 40 1 0001
store 80 0003
store 80 0002
store 80 0001
acc 0000
test wrap 6
mem 00 3 6010 3080 F000
mem 10 1 50FF
mem FF 1 2033
store 80 0033
acc 0033

//--- filelist.f
+incdir+.
cpuPkg.sv
arithUnit.sv
logicUnit.sv
mainMemory.sv
cpuControl.sv
computer.sv
computerChecker.sv
computerTb.sv

//--- Bender.yml
package:
  name: computer

sources:
  - include_dirs:
      - .
    files:
      - cpuPkg.sv
      - arithUnit.sv
      - logicUnit.sv
      - mainMemory.sv
      - cpuControl.sv
      - computer.sv
  - target: test
    include_dirs:
      - .
    files:
      - computerChecker.sv
      - computerTb.sv
